/* tb.f */
rtl/image_pkg.sv
rtl/kernel_if.sv
rtl/line_buffer.sv
rtl/kernel.sv
rtl/interp_bilinear.sv
rtl/demosaic_top.sv
verif/tb_clock.sv
verif/tb_demosaic.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_demosaic
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_demosaic.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_demosaic;
   import image_pkg::*;

   localparam int pixel_width = 10;
   localparam int data_width  = 16;
   localparam int max_cols    = 32;
   localparam int num_frames  = 12;
   localparam int drain_limit = 50;

   typedef struct {
      int    due;     // Cycle the word must appear in
      int    dtype;
      int    meta;
      bit    is_pix;
      int    r;
      int    g;
      int    b;
      string tag;
   } exp_t;

   wire                    clk;
   wire                    resetb;
   logic                   enable;
   logic                   dvi;
   dtype_t                 dtypei;
   logic [data_width-1:0]  datai;
   logic [1:0]             phase;
   logic                   dvo;
   logic [pixel_width-1:0] r;
   logic [pixel_width-1:0] g;
   logic [pixel_width-1:0] b;
   dtype_t                 dtypeo;
   logic [data_width-1:0]  meta_datao;

   integer seed = 32'h50fa_c86e;
   int     cycle;
   int     phase_hold;
   int     frame_phase;
   int     row_phase_in;
   logic [data_width-1:0] pix_data [10][20];
   exp_t   exp_q [$];

   tb_clock #(.period(40)) clkgen (.clk(clk), .resetb(resetb));

   demosaic_top #(
      .pixel_width (pixel_width),
      .data_width  (data_width),
      .max_cols    (max_cols)
   ) dut (
      .clk        (clk),
      .resetb     (resetb),
      .enable     (enable),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .datai      (datai),
      .phase      (phase),
      .dvo        (dvo),
      .r          (r),
      .g          (g),
      .b          (b),
      .dtypeo     (dtypeo),
      .meta_datao (meta_datao)
   );

   function automatic int rand_range(input int lo, input int hi);
      logic [31:0] v;
      v = $random(seed);
      return lo + int'(v % (hi - lo + 1));
   endfunction

   function automatic int sample_at(input int y, input int x);
      return int'(pix_data[y][x][pixel_width-1:0]);
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TB FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
         abort_run($sformatf("** Error %s: expected %0h, actual %0h", name, expected, actual));
   endtask

   task automatic sample_outputs();
      exp_t e;
      if (dvo) begin
         if (exp_q.size() == 0) begin
            abort_run($sformatf("Output word at cycle %0d was not expected", cycle));
         end else begin
            e = exp_q.pop_front();
            check_value({e.tag, " cycle"}, e.due, cycle);
            check_value({e.tag, " dtype"}, e.dtype, 32'(dtypeo));
            if (e.is_pix) begin
               check_value({e.tag, " red"}, e.r, 32'(r));
               check_value({e.tag, " green"}, e.g, 32'(g));
               check_value({e.tag, " blue"}, e.b, 32'(b));
            end else begin
               check_value({e.tag, " meta"}, e.meta, 32'(meta_datao));
            end
         end
      end else if (exp_q.size() > 0 && exp_q[0].due <= cycle) begin
         abort_run($sformatf("Output word %s never arrived by cycle %0d", exp_q[0].tag, cycle));
      end
   endtask

   // Advance to the next falling edge, check outputs, default the inputs
   task automatic tick();
      @(negedge clk);
      cycle++;
      sample_outputs();
      enable = 1'b1;
      dvi    = 1'b0;
      dtypei = dtype_frame_end;
      if (phase_hold > 0)
         phase_hold--;
      else if (rand_range(0, 15) == 0)
         phase = 2'(rand_range(0, 3));   // Mid-frame phase change
   endtask

   task automatic idle_gap();
      logic [31:0] rnd;
      int          n;
      n = rand_range(0, 2);
      for (int i = 0; i < n; i++) begin
         tick();
         rnd = $random(seed);
         if (rnd[31:30] == 2'b00) begin   // Enable low word that must vanish
            enable = 1'b0;
            dvi    = 1'b1;
            dtypei = rnd[16] ? dtype_pixel : dtype_row_start;
            datai  = rnd[15:0];
         end
      end
   endtask

   task automatic drive_word(input dtype_t dt, input logic [data_width-1:0] data);
      idle_gap();
      tick();
      enable = 1'b1;
      dvi    = 1'b1;
      dtypei = dt;
      datai  = data;
   endtask

   task automatic send_ctrl(input dtype_t dt, input bit kept, input string tag);
      logic [31:0] rnd;
      exp_t        e;
      rnd = $random(seed);
      drive_word(dt, rnd[data_width-1:0]);
      if (kept) begin
         e.due    = cycle + 3;
         e.dtype  = int'(dt);
         e.meta   = int'(rnd[data_width-1:0]);
         e.is_pix = 1'b0;
         e.tag    = tag;
         exp_q.push_back(e);
      end
   endtask

   // Expected colour for the window centred one row up and one column left
   task automatic push_pixel(input int f, input int y, input int x);
      exp_t e;
      int   cy, cx, c, up, dn, lf, rt;
      int   plus, diam, vert, horz, site;
      cy = y - 1;
      cx = x - 1;
      c  = sample_at(cy, cx);
      up = sample_at(cy - 1, cx);
      dn = sample_at(cy + 1, cx);
      lf = sample_at(cy, cx - 1);
      rt = sample_at(cy, cx + 1);
      plus = (up + dn + lf + rt) / 4;
      diam = (sample_at(cy - 1, cx - 1) + sample_at(cy - 1, cx + 1) +
              sample_at(cy + 1, cx - 1) + sample_at(cy + 1, cx + 1)) / 4;
      vert = (up + dn) / 2;
      horz = (lf + rt) / 2;
      site = ((((frame_phase >> 1) & 1) ^ ((y - 2) & 1)) * 2) +
             ((row_phase_in & 1) ^ ((x - 2) & 1));
      case (site)
         0: begin
            e.r = c;
            e.g = plus;
            e.b = diam;
         end
         1: begin
            e.r = horz;
            e.g = c;
            e.b = vert;
         end
         2: begin
            e.r = vert;
            e.g = c;
            e.b = horz;
         end
         default: begin
            e.r = diam;
            e.g = plus;
            e.b = c;
         end
      endcase
      e.due    = cycle + 3;
      e.dtype  = int'(dtype_pixel);
      e.is_pix = 1'b1;
      e.tag    = $sformatf("frame %0d pixel y%0d x%0d", f, cy, cx);
      exp_q.push_back(e);
   endtask

   task automatic run_frame(input int f);
      int cols;
      int rows;
      cols = rand_range(4, 20);
      rows = rand_range(4, 10);
      for (int y = 0; y < rows; y++)
         for (int x = 0; x < cols; x++)
            pix_data[y][x] = data_width'($random(seed));
      send_ctrl(dtype_frame_start, 1'b1, $sformatf("frame %0d frame_start", f));
      phase       = 2'(f % 4);   // Row phase fixed for the whole frame
      frame_phase = f % 4;
      phase_hold  = 3;
      for (int y = 0; y < rows; y++) begin
         send_ctrl(dtype_row_start, y >= 2, $sformatf("frame %0d row_start %0d", f, y));
         phase_hold   = 3;
         row_phase_in = int'(phase);
         for (int x = 0; x < cols; x++) begin
            drive_word(dtype_pixel, pix_data[y][x]);
            if (y >= 2 && x >= 2)
               push_pixel(f, y, x);
         end
         send_ctrl(dtype_row_end, y >= 2, $sformatf("frame %0d row_end %0d", f, y));
      end
      send_ctrl(dtype_frame_end, 1'b1, $sformatf("frame %0d frame_end", f));
   endtask

   initial begin
      enable       = 1'b0;
      dvi          = 1'b0;
      dtypei       = dtype_frame_end;
      datai        = '0;
      phase        = 2'b00;
      cycle        = 0;
      phase_hold   = 0;
      frame_phase  = 0;
      row_phase_in = 0;
      for (int n = 0; n < 20 && resetb !== 1'b1; n++)
         @(negedge clk);
      if (resetb !== 1'b1) begin
         abort_run("Reset was never released");
      end else begin
         for (int n = 0; n < 4; n++) begin
            tick();
            check_value("reset dvo", 32'd0, 32'(dvo));
            check_value("reset red", 32'd0, 32'(r));
            check_value("reset green", 32'd0, 32'(g));
            check_value("reset blue", 32'd0, 32'(b));
            check_value("reset dtypeo", 32'd0, 32'(dtypeo));
            check_value("reset meta", 32'd0, 32'(meta_datao));
         end
         for (int f = 0; f < num_frames; f++)
            run_frame(f);
         for (int n = 0; n < drain_limit && exp_q.size() > 0; n++)
            tick();
         for (int n = 0; n < 4; n++)
            tick();   // Catch stray words after the last frame
         if (exp_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
         end else begin
            abort_run($sformatf("Output word %s never arrived", exp_q[0].tag));
         end
      end
   end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
   parameter int period = 40
) (
   output logic clk,
   output logic resetb
);

   initial begin
      clk = 1'b0;
      forever #(period/2) clk = ~clk;
   end

   // Reset held low for two rising edges
   initial begin
      resetb = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      resetb = 1'b1;
   end

endmodule

`default_nettype wire

/* rtl/demosaic_top.sv */
`timescale 1ns/100ps
`default_nettype none

module demosaic_top #(
   parameter int pixel_width = 10,
   parameter int data_width  = 16,
   parameter int max_cols    = 1288
) (
   input  wire                     clk,
   input  wire                     resetb,
   input  wire                     enable,
   input  wire                     dvi,
   input  wire image_pkg::dtype_t  dtypei,
   input  wire [data_width-1:0]    datai,
   input  wire [1:0]               phase,
   output logic                    dvo,
   output logic [pixel_width-1:0]  r,
   output logic [pixel_width-1:0]  g,
   output logic [pixel_width-1:0]  b,
   output image_pkg::dtype_t       dtypeo,
   output logic [data_width-1:0]   meta_datao
);

   kernel_if #(.pixel_width(pixel_width), .data_width(data_width)) k_if ();

   // 2 cycle window stage
   kernel #(
      .pixel_width (pixel_width),
      .data_width  (data_width),
      .max_cols    (max_cols)
   ) u_kernel (
      .clk    (clk),
      .resetb (resetb),
      .enable (enable),
      .dvi    (dvi),
      .dtypei (dtypei),
      .datai  (datai),
      .kout   (k_if.source)
   );

   interp_bilinear #(
      .pixel_width (pixel_width),
      .data_width  (data_width)
   ) u_interp (
      .clk        (clk),
      .resetb     (resetb),
      .phase      (phase),
      .kin        (k_if.sink),
      .dvo        (dvo),
      .r          (r),
      .g          (g),
      .b          (b),
      .dtypeo     (dtypeo),
      .meta_datao (meta_datao)
   );

endmodule

`default_nettype wire

/* rtl/interp_bilinear.sv */
`timescale 1ns/100ps
`default_nettype none

module interp_bilinear #(
   parameter int pixel_width = 10,
   parameter int data_width  = 16
) (
   input  wire                     clk,
   input  wire                     resetb,
   input  wire [1:0]               phase,
   kernel_if.sink                  kin,
   output logic                    dvo,
   output logic [pixel_width-1:0]  r,
   output logic [pixel_width-1:0]  g,
   output logic [pixel_width-1:0]  b,
   output image_pkg::dtype_t       dtypeo,
   output logic [data_width-1:0]   meta_datao
);
   import image_pkg::*;

   typedef logic [pixel_width-1:0] pix_t;
   typedef enum logic [1:0] {
      site_r,
      site_gr,   // Green on a red row
      site_gb,   // Green on a blue row
      site_b
   } site_t;

   pix_t k [3][3];
   logic [pixel_width+1:0] plus_sum, diamond_sum;
   logic [pixel_width:0]   vert_sum, horz_sum;
   pix_t  kcenter, kplus, kdiamond, kvert, khorz;
   logic  row_phase, col_phase;
   logic  in_row;
   logic  is_pix;
   site_t site;

   always_comb begin
      for (int i = 0; i < 3; i++) begin
         for (int j = 0; j < 3; j++) begin
            k[i][j] = kin.window[(i*3+j)*pixel_width +: pixel_width];
         end
      end
   end

   assign plus_sum    = {2'b00, k[0][1]} + {2'b00, k[2][1]} + {2'b00, k[1][0]} + {2'b00, k[1][2]};
   assign diamond_sum = {2'b00, k[0][0]} + {2'b00, k[0][2]} + {2'b00, k[2][0]} + {2'b00, k[2][2]};
   assign vert_sum    = {1'b0, k[0][1]} + {1'b0, k[2][1]};
   assign horz_sum    = {1'b0, k[1][0]} + {1'b0, k[1][2]};

   // Floor averages
   assign kcenter  = k[1][1];
   assign kplus    = plus_sum[pixel_width+1:2];
   assign kdiamond = diamond_sum[pixel_width+1:2];
   assign kvert    = vert_sum[pixel_width:1];
   assign khorz    = horz_sum[pixel_width:1];

   assign is_pix = |(kin.dtype & pixel_mask);
   assign site   = site_t'({row_phase, col_phase});

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo        <= 1'b0;
         dtypeo     <= '0;
         meta_datao <= '0;
         r          <= '0;
         g          <= '0;
         b          <= '0;
         row_phase  <= 1'b0;
         col_phase  <= 1'b0;
         in_row     <= 1'b0;
      end else begin
         dvo        <= kin.dv;
         dtypeo     <= kin.dtype;
         meta_datao <= kin.meta_data;
         if (kin.dv) begin
            if (kin.dtype == dtype_frame_start) begin
               row_phase <= phase[1];
            end else if (kin.dtype == dtype_row_start) begin
               col_phase <= phase[0];
               in_row    <= 1'b1;
            end else if (kin.dtype == dtype_row_end) begin
               row_phase <= ~row_phase;
               in_row    <= 1'b0;
            end else if (is_pix) begin
               col_phase <= ~col_phase;
               case (site)
                  site_r: begin
                     r <= kcenter;
                     g <= kplus;
                     b <= kdiamond;
                  end
                  site_gr: begin
                     r <= khorz;
                     g <= kcenter;
                     b <= kvert;
                  end
                  site_gb: begin
                     r <= kvert;
                     g <= kcenter;
                     b <= khorz;
                  end
                  default: begin   // Blue site
                     r <= kdiamond;
                     g <= kplus;
                     b <= kcenter;
                  end
               endcase
            end
         end
      end
   end

   a_pix_in_row: assert property (
      @(posedge clk) disable iff (!resetb)
      (kin.dv && is_pix) |-> in_row
   ) else $error("pixel word outside a row");

endmodule

`default_nettype wire

/* rtl/kernel.sv */
`timescale 1ns/100ps
`default_nettype none

module kernel #(
   parameter int pixel_width = 10,
   parameter int data_width  = 16,
   parameter int max_cols    = 1288
) (
   input  wire                    clk,
   input  wire                    resetb,
   input  wire                    enable,
   input  wire                    dvi,
   input  wire image_pkg::dtype_t dtypei,
   input  wire [data_width-1:0]   datai,
   kernel_if.source               kout
);
   import image_pkg::*;

   localparam int col_width = $clog2(max_cols);

   typedef logic [pixel_width-1:0] pix_t;
   typedef logic [col_width-1:0]   col_t;
   typedef logic [data_width-1:0]  data_t;

   logic  in_word;
   logic  in_pix;
   logic  keep;
   col_t  col_cnt;
   logic [1:0] row_cnt;   // Saturates at 2

   logic  s1_dv, s1_pix;
   dtype_t s1_dtype;
   data_t s1_data;
   col_t  s1_col;
   pix_t  s1_val;

   logic  s2_dv, s2_pix;
   dtype_t s2_dtype;
   data_t s2_data;
   pix_t  s2_bot, s2_mid;

   pix_t  lb0_dout, lb1_dout;
   pix_t  cur [3];
   pix_t  c1 [3];
   pix_t  c2 [3];
   logic [9*pixel_width-1:0] window;

   assign in_word = enable & dvi;
   assign in_pix  = in_word & (|(dtypei & pixel_mask));

   // Border suppression
   always_comb begin
      if (|(dtypei & pixel_mask))
         keep = (row_cnt == 2'd2) && (col_cnt >= col_t'(2));
      else if (dtypei == dtype_row_start || dtypei == dtype_row_end)
         keep = (row_cnt == 2'd2);
      else
         keep = 1'b1;
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         col_cnt <= '0;
         row_cnt <= '0;
      end else if (in_word) begin
         if (dtypei == dtype_frame_start)
            row_cnt <= '0;
         else if (dtypei == dtype_row_end && row_cnt != 2'd2)
            row_cnt <= row_cnt + 2'd1;
         if (dtypei == dtype_row_start)
            col_cnt <= '0;
         else if (in_pix)
            col_cnt <= col_cnt + col_t'(1);
      end
   end

   line_buffer #(.pixel_width(pixel_width), .max_cols(max_cols)) lb0 (
      .clk    (clk),
      .resetb (resetb),
      .shift  (in_pix),
      .col    (col_cnt),
      .din    (datai[pixel_width-1:0]),
      .dout   (lb0_dout)                 // Row y-1
   );

   line_buffer #(.pixel_width(pixel_width), .max_cols(max_cols)) lb1 (
      .clk    (clk),
      .resetb (resetb),
      .shift  (s1_pix),
      .col    (s1_col),
      .din    (lb0_dout),
      .dout   (lb1_dout)                 // Row y-2
   );

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         s1_dv    <= 1'b0;
         s1_pix   <= 1'b0;
         s1_dtype <= '0;
         s1_data  <= '0;
         s2_dv    <= 1'b0;
         s2_pix   <= 1'b0;
         s2_dtype <= '0;
         s2_data  <= '0;
      end else begin
         s1_dv  <= in_word & keep;
         s1_pix <= in_pix;
         if (in_word) begin
            s1_dtype <= dtypei;
            s1_data  <= datai;
         end
         s2_dv    <= s1_dv;
         s2_pix   <= s1_pix;
         s2_dtype <= s1_dtype;
         s2_data  <= s1_data;
      end
   end

   always_ff @(posedge clk) begin
      if (in_pix) begin
         s1_col <= col_cnt;
         s1_val <= datai[pixel_width-1:0];
      end
      if (s1_pix) begin
         s2_bot <= s1_val;
         s2_mid <= lb0_dout;
      end
      if (s2_pix) begin   // Window slides one column
         c1 <= cur;
         c2 <= c1;
      end
   end

   assign cur[0] = lb1_dout;
   assign cur[1] = s2_mid;
   assign cur[2] = s2_bot;

   always_comb begin
      for (int i = 0; i < 3; i++) begin
         window[(i*3+0)*pixel_width +: pixel_width] = c2[i];
         window[(i*3+1)*pixel_width +: pixel_width] = c1[i];
         window[(i*3+2)*pixel_width +: pixel_width] = cur[i];
      end
   end

   assign kout.dv        = s2_dv;
   assign kout.dtype     = s2_dtype;
   assign kout.meta_data = s2_data;
   assign kout.window    = window;

   a_dtype_onehot: assert property (
      @(posedge clk) disable iff (!resetb)
      dvi |-> $onehot0(dtypei)
   ) else $error("kernel input dtype %b is not one-hot", dtypei);

endmodule

`default_nettype wire

/* rtl/line_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module line_buffer #(
   parameter int pixel_width = 10,
   parameter int max_cols    = 1288
) (
   input  wire                        clk,
   input  wire                        resetb,
   input  wire                        shift,
   input  wire [$clog2(max_cols)-1:0] col,
   input  wire [pixel_width-1:0]      din,
   output logic [pixel_width-1:0]     dout
);

   typedef logic [pixel_width-1:0] pix_t;

   pix_t mem [max_cols];

   // Old sample read out as the new one goes in
   always_ff @(posedge clk) begin
      if (shift) begin
         dout     <= mem[col];
         mem[col] <= din;
      end
   end

   a_col_range: assert property (
      @(posedge clk) disable iff (!resetb)
      shift |-> (int'(col) < max_cols)
   ) else $error("line_buffer column %0d beyond max_cols", col);

endmodule

`default_nettype wire

/* rtl/kernel_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface kernel_if #(
   parameter int pixel_width = 10,
   parameter int data_width  = 16
);
   import image_pkg::*;

   logic                     dv;
   dtype_t                   dtype;
   logic [data_width-1:0]    meta_data;
   // Nine pixels, row-major, top-left pixel in the lowest bits
   logic [9*pixel_width-1:0] window;

   modport source (output dv, dtype, meta_data, window);
   modport sink   (input  dv, dtype, meta_data, window);

endinterface

`default_nettype wire

/* rtl/image_pkg.sv */
`default_nettype none

package image_pkg;

   localparam int dtype_width = 4;

   typedef logic [dtype_width-1:0] dtype_t;

   // Stream word type codes
   localparam dtype_t dtype_frame_start = 4'b0001;
   localparam dtype_t dtype_row_start   = 4'b0010;
   localparam dtype_t dtype_row_end     = 4'b0100;
   localparam dtype_t dtype_pixel       = 4'b1000;

   // Frame end is the all-zero code
   localparam dtype_t dtype_frame_end   = 4'b0000;

   localparam dtype_t pixel_mask        = dtype_pixel;

endpackage

`default_nettype wire
